// ==== Bender.yml ====
package:
  name: rvc_fetch

sources:
  - files:
      - logic/rvc_fetch_pkg.sv
      - logic/fetch_wb_master.sv
      - logic/parcel_aligner.sv
      - logic/rvc_expander.sv
      - logic/instr_issue.sv
      - logic/rvc_fetch_top.sv
  - target: test
    files:
      - test/rvc_fetch_tb.sv

// ==== logic/fetch_wb_master.sv ====
`timescale 1ns/1ps

module fetch_wb_master (
    input  logic                           clk_i,
    input  logic                           rst_i,
    output logic                           wb_cyc_o,
    output logic                           wb_stb_o,
    output logic                           wb_we_o,
    output logic [rvc_fetch_pkg::XLEN-1:0] wb_adr_o,
    output logic [3:0]                     wb_sel_o,
    input  logic [rvc_fetch_pkg::XLEN-1:0] wb_dat_i,
    input  logic                           wb_ack_i,
    output logic                           word_valid_o,
    output logic [rvc_fetch_pkg::XLEN-1:0] word_data_o,
    input  logic                           word_take_i
);
    import rvc_fetch_pkg::*;

    logic            cyc_q;                     // bus cycle open
    logic            held_q;                    // fetched word waiting for the aligner
    logic [XLEN-1:0] adr_q;
    logic [XLEN-1:0] data_q;

    // ------------------------------------------------------------------------
    // bus engine
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cyc_q  <= 1'b0;
            held_q <= 1'b0;
            adr_q  <= RESET_PC;
        end else if (cyc_q) begin
            if (wb_ack_i) begin
                cyc_q  <= 1'b0;                 // drop the cycle after ack
                held_q <= 1'b1;
                adr_q  <= adr_q + XLEN'(4);     // next sequential word
            end
        end else if (!held_q || word_take_i) begin
            cyc_q  <= 1'b1;                     // start up, or word was taken
            held_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cyc_q && wb_ack_i) begin
            data_q <= wb_dat_i;
        end
    end

    assign wb_cyc_o     = cyc_q;
    assign wb_stb_o     = cyc_q;                // classic, one transfer per cycle
    assign wb_we_o      = 1'b0;                 // read only
    assign wb_sel_o     = 4'hf;
    assign wb_adr_o     = adr_q;
    assign word_valid_o = held_q;
    assign word_data_o  = data_q;

    stb_in_cyc_a: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_stb_o |-> wb_cyc_o);

    adr_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o));

endmodule

// ==== logic/instr_issue.sv ====
`timescale 1ns/1ps

module instr_issue (
    input  logic                                                      clk_i,
    input  logic                                                      rst_i,
    input  rvc_fetch_pkg::window_t                                    window_i,
    input  rvc_fetch_pkg::lane_t [rvc_fetch_pkg::NUM_LANES-1:0]       lanes_i,
    output logic [2:0]                                                consume_o,
    output logic                                                      out_valid_o,
    output rvc_fetch_pkg::fetch_instr_t [rvc_fetch_pkg::NUM_LANES-1:0] out_slots_o,
    input  logic                                                      out_ready_i
);
    import rvc_fetch_pkg::*;

    logic [XLEN-1:0] pc_q;                      // pc of window halfword 0
    logic [2:0]      slot_halves;               // halfwords of all valid slots
    logic            fire;

    // ------------------------------------------------------------------------
    // slot rules, lane k starts at halfword k
    // ------------------------------------------------------------------------
    always_comb begin
        logic chain;
        int   avail;
        chain       = 1'b1;
        slot_halves = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            avail = int'(window_i.count) - k;
            chain = chain && (avail >= 1) && (!lanes_i[k].need || avail >= 2);
            out_slots_o[k].valid   = chain;
            out_slots_o[k].pc      = pc_q + XLEN'(2 * k);
            out_slots_o[k].instr   = lanes_i[k].instr;
            out_slots_o[k].rvc     = lanes_i[k].rvc;
            out_slots_o[k].illegal = lanes_i[k].illegal;
            if (chain) begin
                slot_halves = slot_halves + (lanes_i[k].need ? 3'd2 : 3'd1);
            end
            chain = chain && lanes_i[k].rvc;    // next lane only after a compressed one
        end
    end

    assign out_valid_o = out_slots_o[0].valid;
    assign fire        = out_valid_o && out_ready_i;
    assign consume_o   = fire ? slot_halves : 3'd0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_q + {{(XLEN-4){1'b0}}, consume_o, 1'b0};   // 2 bytes per halfword
        end
    end

    // a stalled slot 1 may still turn valid as new words arrive
    hold_while_stalled_a: assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_slots_o[0]) &&
            (!$past(out_slots_o[1].valid) || $stable(out_slots_o[1])));

endmodule

// ==== logic/parcel_aligner.sv ====
`timescale 1ns/1ps

module parcel_aligner (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           word_valid_i,
    input  logic [rvc_fetch_pkg::XLEN-1:0] word_data_i,
    output logic                           word_take_o,
    input  logic [2:0]                     consume_i,
    output rvc_fetch_pkg::window_t         window_o
);
    import rvc_fetch_pkg::*;

    logic [BUF_HALVES-1:0][15:0] half_q;
    logic [BUF_HALVES-1:0][15:0] half_d;
    logic [2:0]                  count_q;
    logic [2:0]                  count_d;
    logic [2:0]                  remain;        // halfwords left after consume

    assign remain = count_q - consume_i;

    // a word only fits if the post-consume space holds both halves
    assign word_take_o = word_valid_i && (int'(remain) + 2 <= BUF_HALVES);

    // ------------------------------------------------------------------------
    // shift out consumed halfwords, append the new word above the rest
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < BUF_HALVES; i++) begin
            if (i + int'(consume_i) < BUF_HALVES) begin
                half_d[i] = half_q[i + int'(consume_i)];
            end else begin
                half_d[i] = '0;
            end
            if (word_take_o && i == int'(remain)) begin
                half_d[i] = word_data_i[15:0];          // little-endian, low half first
            end
            if (word_take_o && i == int'(remain) + 1) begin
                half_d[i] = word_data_i[XLEN-1:16];
            end
        end
        count_d = remain + (word_take_o ? 3'd2 : 3'd0);
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    always_ff @(posedge clk_i) begin
        half_q <= half_d;
    end

    assign window_o.halfwords = half_q;
    assign window_o.count     = count_q;

    consume_le_count_a: assert property (@(posedge clk_i) disable iff (rst_i)
        consume_i <= count_q);

    count_le_depth_a: assert property (@(posedge clk_i) disable iff (rst_i)
        int'(count_q) <= BUF_HALVES);

endmodule

// ==== logic/rvc_expander.sv ====
`timescale 1ns/1ps

module rvc_expander (
    input  rvc_fetch_pkg::parcel_u parcel_i,
    output rvc_fetch_pkg::lane_t   lane_o
);
    import rvc_fetch_pkg::*;

    logic [15:0]     c;                         // compressed parcel
    logic [4:0]      rd;
    logic [4:0]      rs2;
    logic [4:0]      rdp;                       // rd'/rs1' field, x8..x15
    logic [4:0]      rs2p;                      // rs2'/rd' field, x8..x15
    logic [11:0]     imm6;                      // sign-extended 6-bit immediate
    logic [11:1]     joff;                      // c.j / c.jal offset
    logic            imm_zero;
    logic [2:0]      alu_f3;
    logic [XLEN-1:0] exp_instr;
    logic            reserved;

    assign c        = parcel_i.halves.lo;
    assign rd       = c[11:7];
    assign rs2      = c[6:2];
    assign rdp      = {2'b01, c[9:7]};
    assign rs2p     = {2'b01, c[4:2]};
    assign imm6     = {{7{c[12]}}, c[6:2]};
    assign joff     = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3]};
    assign imm_zero = !c[12] && (c[6:2] == 5'd0);

    // sub/xor/or/and from bits 6:5 -> 000/100/110/111
    assign alu_f3   = {c[6] | c[5], c[6], c[6] & c[5]};

    // ------------------------------------------------------------------------
    // quadrant and funct3 decode
    // ------------------------------------------------------------------------
    always_comb begin
        exp_instr = '0;
        reserved  = 1'b0;
        case ({c[1:0], c[15:13]})
            5'b00_000: begin                    // c.addi4spn
                reserved  = (c[12:5] == 8'd0);
                exp_instr = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                             5'd2, 3'b000, rs2p, 7'b0010011};
            end
            5'b00_010: exp_instr = {5'b0, c[5], c[12:10], c[6], 2'b00, rdp, 3'b010,
                                    rs2p, 7'b0000011};                      // c.lw
            5'b00_110: exp_instr = {5'b0, c[5], c[12], rs2p, rdp, 3'b010, c[11:10],
                                    c[6], 2'b00, 7'b0100011};               // c.sw
            5'b01_000: begin                    // c.addi, c.nop when all zero
                reserved  = imm_zero && (rd != 5'd0);
                exp_instr = {imm6, rd, 3'b000, rd, 7'b0010011};
            end
            5'b01_001, 5'b01_101: begin         // c.jal links x1, c.j links x0
                exp_instr = {joff[11], joff[10:1], joff[11], {8{joff[11]}},
                             4'b0000, !c[15], 7'b1101111};
            end
            5'b01_010: begin                    // c.li
                reserved  = (rd == 5'd0);
                exp_instr = {imm6, 5'd0, 3'b000, rd, 7'b0010011};
            end
            5'b01_011: begin
                reserved = imm_zero || (rd == 5'd0);
                if (rd == 5'd2) begin           // c.addi16sp
                    exp_instr = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000,
                                 5'd2, 3'b000, 5'd2, 7'b0010011};
                end else begin                  // c.lui
                    exp_instr = {{15{c[12]}}, c[6:2], rd, 7'b0110111};
                end
            end
            5'b01_100: begin
                case (c[11:10])
                    2'b00, 2'b01: begin         // c.srli, c.srai
                        reserved  = imm_zero;
                        exp_instr = {1'b0, c[10], 5'b00000, c[6:2], rdp, 3'b101,
                                     rdp, 7'b0010011};
                    end
                    2'b10: exp_instr = {imm6, rdp, 3'b111, rdp, 7'b0010011}; // c.andi
                    default: begin              // c.sub c.xor c.or c.and
                        reserved  = c[12];
                        exp_instr = {1'b0, c[6:5] == 2'b00, 5'b00000, rs2p, rdp,
                                     alu_f3, rdp, 7'b0110011};
                    end
                endcase
            end
            5'b01_110, 5'b01_111: begin         // c.beqz, c.bnez
                exp_instr = {{4{c[12]}}, c[6:5], c[2], 5'd0, rdp, 2'b00, c[13],
                             c[11:10], c[4:3], c[12], 7'b1100011};
            end
            5'b10_000: begin                    // c.slli
                reserved  = c[12] || (c[6:2] == 5'd0) || (rd == 5'd0);
                exp_instr = {7'b0, c[6:2], rd, 3'b001, rd, 7'b0010011};
            end
            5'b10_010: begin                    // c.lwsp
                reserved  = (rd == 5'd0);
                exp_instr = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010,
                             rd, 7'b0000011};
            end
            5'b10_110: exp_instr = {4'b0, c[8:7], c[12], rs2, 5'd2, 3'b010, c[11:9],
                                    2'b00, 7'b0100011};                     // c.swsp
            5'b10_100: begin
                if (rs2 == 5'd0 && rd == 5'd0) begin
                    reserved  = !c[12];
                    exp_instr = 32'h0010_0073;  // c.ebreak
                end else if (rs2 == 5'd0) begin // c.jr, c.jalr
                    exp_instr = {12'b0, rd, 3'b000, 4'b0000, c[12], 7'b1100111};
                end else begin                  // c.mv, c.add
                    reserved  = (rd == 5'd0);
                    exp_instr = {7'b0, rs2, c[12] ? rd : 5'd0, 3'b000, rd, 7'b0110011};
                end
            end
            default: reserved = 1'b1;
        endcase
    end

    always_comb begin
        if (c[1:0] == 2'b11) begin              // 32-bit parcel, pass through
            lane_o.instr   = parcel_i.word;
            lane_o.rvc     = 1'b0;
            lane_o.illegal = 1'b0;
            lane_o.need    = 1'b1;
        end else begin
            lane_o.instr   = reserved ? '0 : exp_instr;
            lane_o.rvc     = 1'b1;
            lane_o.illegal = reserved;
            lane_o.need    = 1'b0;
        end
    end

endmodule

// ==== logic/rvc_fetch_pkg.sv ====
package rvc_fetch_pkg;

    // ------------------------------------------------------------------------
    // fetch front end parameters
    // ------------------------------------------------------------------------
    localparam int XLEN       = 32;             // instruction and address width
    localparam int NUM_LANES  = 2;              // expander lanes, output slots
    localparam int BUF_HALVES = 4;              // aligner depth in halfwords

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // ------------------------------------------------------------------------
    // parcel and stream types
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [15:0] hi;                        // second halfword of the parcel
        logic [15:0] lo;                        // first halfword, holds op and funct3
    } parcel_halves_t;

    // one parcel, read whole for pass-through or by halfword for decode
    typedef union packed {
        logic [XLEN-1:0] word;
        parcel_halves_t  halves;
    } parcel_u;

    typedef struct packed {
        logic [BUF_HALVES-1:0][15:0] halfwords; // index 0 is the oldest
        logic [2:0]                  count;     // valid halfwords from index 0
    } window_t;

    typedef struct packed {
        logic [XLEN-1:0] instr;                 // expanded or passed-through
        logic            rvc;
        logic            illegal;
        logic            need;                  // extra halfwords after the first
    } lane_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        logic            rvc;
        logic            illegal;
    } fetch_instr_t;

endpackage

// ==== logic/rvc_fetch_top.sv ====
`timescale 1ns/1ps

module rvc_fetch_top (
    input  logic                                                      clk_i,
    input  logic                                                      rst_i,
    output logic                                                      wb_cyc_o,
    output logic                                                      wb_stb_o,
    output logic                                                      wb_we_o,
    output logic [rvc_fetch_pkg::XLEN-1:0]                            wb_adr_o,
    output logic [3:0]                                                wb_sel_o,
    input  logic [rvc_fetch_pkg::XLEN-1:0]                            wb_dat_i,
    input  logic                                                      wb_ack_i,
    output logic                                                      out_valid_o,
    output rvc_fetch_pkg::fetch_instr_t [rvc_fetch_pkg::NUM_LANES-1:0] out_slots_o,
    input  logic                                                      out_ready_i
);
    import rvc_fetch_pkg::*;

    logic                       word_valid;
    logic [XLEN-1:0]            word_data;
    logic                       word_take;
    logic [2:0]                 consume;
    window_t                    window;
    lane_t [NUM_LANES-1:0]      lanes;

    fetch_wb_master fetch_wb_master_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_we_o      (wb_we_o),
        .wb_adr_o     (wb_adr_o),
        .wb_sel_o     (wb_sel_o),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .word_valid_o (word_valid),
        .word_data_o  (word_data),
        .word_take_i  (word_take)
    );

    parcel_aligner parcel_aligner_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .word_valid_i (word_valid),
        .word_data_i  (word_data),
        .word_take_o  (word_take),
        .consume_i    (consume),
        .window_o     (window)
    );

    // ------------------------------------------------------------------------
    // expander lanes, lane k sees halfwords k and k+1
    // ------------------------------------------------------------------------
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        parcel_u lane_parcel;

        assign lane_parcel.halves.lo = window.halfwords[k];
        assign lane_parcel.halves.hi = window.halfwords[k+1];

        rvc_expander rvc_expander_inst (
            .parcel_i (lane_parcel),
            .lane_o   (lanes[k])
        );
    end

    instr_issue instr_issue_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .window_i    (window),
        .lanes_i     (lanes),
        .consume_o   (consume),
        .out_valid_o (out_valid_o),
        .out_slots_o (out_slots_o),
        .out_ready_i (out_ready_i)
    );

endmodule

// ==== rvc_fetch_top.f ====
logic/rvc_fetch_pkg.sv
logic/fetch_wb_master.sv
logic/parcel_aligner.sv
logic/rvc_expander.sv
logic/instr_issue.sv
logic/rvc_fetch_top.sv
test/rvc_fetch_tb.sv

// ==== test/rvc_fetch_tb.sv ====
`timescale 1ns/1ps

module rvc_fetch_tb;
    import rvc_fetch_pkg::*;

    typedef struct packed {
        logic [31:0] parcel;                    // low halfword is fetched first
        logic [1:0]  len;                       // halfwords
        logic [31:0] instr;                     // expected expansion
        logic        illegal;
    } row_t;

    localparam int MEM_HALVES   = 128;
    localparam int BEAT_TIMEOUT = 100;          // cycles without a transferring beat

    logic                         clk_i       = 1'b0;
    logic                         rst_i       = 1'b1;
    logic                         wb_cyc_o;
    logic                         wb_stb_o;
    logic                         wb_we_o;
    logic [XLEN-1:0]              wb_adr_o;
    logic [3:0]                   wb_sel_o;
    logic [XLEN-1:0]              wb_dat_i    = '0;
    logic                         wb_ack_i    = 1'b0;
    logic                         out_valid_o;
    fetch_instr_t [NUM_LANES-1:0] out_slots_o;
    logic                         out_ready_i = 1'b0;

    row_t                         prog[$];
    logic [15:0]                  mem_half [MEM_HALVES];
    int                           wait_left;    // wait states left in this transfer
    logic                         stalled = 1'b0;
    fetch_instr_t [NUM_LANES-1:0] held_slots;

    rvc_fetch_top rvc_fetch_top_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_sel_o    (wb_sel_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i),
        .out_valid_o (out_valid_o),
        .out_slots_o (out_slots_o),
        .out_ready_i (out_ready_i)
    );

    always #10 clk_i = ~clk_i;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [65:0] got,
                               input logic [65:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic add_row(input logic [31:0] parcel, input int len,
                           input logic [31:0] instr, input logic illegal);
        row_t r;
        r.parcel  = parcel;
        r.len     = 2'(len);
        r.instr   = instr;
        r.illegal = illegal;
        prog.push_back(r);
    endtask

    task automatic load_memory();
        int h;
        h = 0;
        foreach (prog[i]) begin
            mem_half[h] = prog[i].parcel[15:0];
            if (prog[i].len == 2'd2) begin
                mem_half[h+1] = prog[i].parcel[31:16];
            end
            h = h + int'(prog[i].len);
        end
        for (; h < MEM_HALVES; h++) begin
            mem_half[h] = 16'h0001;             // c.nop tail
        end
    endtask

    task automatic check_slot(input int k, input row_t r, input logic [XLEN-1:0] pc);
        string tag;
        tag = $sformatf("out_slots_o[%0d]", k);
        check_value({tag, ".pc"}, out_slots_o[k].pc, pc);
        check_value({tag, ".instr"}, out_slots_o[k].instr, r.instr);
        check_value({tag, ".rvc"}, out_slots_o[k].rvc, r.len == 2'd1);
        check_value({tag, ".illegal"}, out_slots_o[k].illegal, r.illegal);
    endtask

    // ------------------------------------------------------------------------
    // Wishbone slave with 0 to 3 wait states
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (!rst_i) begin
            check_value("wb_stb_o", wb_stb_o, wb_cyc_o);
        end
        if (rst_i) begin
            wb_ack_i  <= 1'b0;
            wait_left <= $urandom % 4;
        end else if (wb_ack_i) begin
            wb_ack_i <= 1'b0;                   // master drops cyc now
        end else if (wb_cyc_o && wb_stb_o) begin
            if (wait_left == 0) begin
                check_value("wb_we_o", wb_we_o, 1'b0);
                check_value("wb_sel_o", wb_sel_o, 4'hf);
                wb_ack_i  <= 1'b1;
                wb_dat_i  <= {mem_half[2 * int'(wb_adr_o[7:2]) + 1],
                              mem_half[2 * int'(wb_adr_o[7:2])]};
                wait_left <= $urandom % 4;
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            out_ready_i <= 1'b0;
        end else begin
            out_ready_i <= ($urandom % 4) != 0; // ready three beats in four
        end
    end

    // valid slots must hold while the core stalls
    always @(negedge clk_i) begin
        if (!rst_i && stalled) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                if (held_slots[k].valid) begin
                    check_value($sformatf("out_slots_o[%0d]", k), out_slots_o[k], held_slots[k]);
                end
            end
        end
        stalled    = !rst_i && out_valid_o && !out_ready_i;
        held_slots = out_slots_o;
    end

    initial begin
        int              row;
        int              cycles;
        logic [XLEN-1:0] exp_pc;
        void'($urandom(32'hfca0));

        // ------------------------------------------------------------------------
        // program table: parcel, halfwords, expected instruction, illegal
        // ------------------------------------------------------------------------
        add_row(32'h0000_0040, 1, 32'h0041_0413, 1'b0);   // c.addi4spn x8, 4
        add_row(32'h0050_0093, 2, 32'h0050_0093, 1'b0);   // straddles words 0 and 1
        add_row(32'h0000_4044, 1, 32'h0044_2483, 1'b0);   // c.lw
        add_row(32'h0000_C044, 1, 32'h0094_2223, 1'b0);   // c.sw
        add_row(32'h0000_0001, 1, 32'h0000_0013, 1'b0);   // c.nop
        add_row(32'h0000_157D, 1, 32'hFFF5_0513, 1'b0);   // c.addi x10, -1
        add_row(32'h0000_2021, 1, 32'h0080_00EF, 1'b0);   // c.jal +8
        add_row(32'h0020_81B3, 2, 32'h0020_81B3, 1'b0);   // aligned
        add_row(32'h0000_4595, 1, 32'h0050_0593, 1'b0);   // c.li
        add_row(32'h0000_6605, 1, 32'h0000_1637, 1'b0);   // c.lui
        add_row(32'h0000_6141, 1, 32'h0101_0113, 1'b0);   // c.addi16sp
        add_row(32'h0000_0000, 1, 32'h0000_0000, 1'b1);   // all zero
        add_row(32'h0000_800D, 1, 32'h0034_5413, 1'b0);   // c.srli
        add_row(32'hDEAD_C0B7, 2, 32'hDEAD_C0B7, 1'b0);   // straddles
        add_row(32'h0000_8491, 1, 32'h4044_D493, 1'b0);   // c.srai
        add_row(32'h0000_9979, 1, 32'hFFE5_7513, 1'b0);   // c.andi
        add_row(32'h0000_8C05, 1, 32'h4094_0433, 1'b0);   // c.sub
        add_row(32'h0000_8C25, 1, 32'h0094_4433, 1'b0);   // c.xor
        add_row(32'h0000_8C45, 1, 32'h0094_6433, 1'b0);   // c.or
        add_row(32'h0000_8C65, 1, 32'h0094_7433, 1'b0);   // c.and
        add_row(32'h0000_4015, 1, 32'h0000_0000, 1'b1);   // c.li x0 reserved
        add_row(32'h0000_BFF5, 1, 32'hFFDF_F06F, 1'b0);   // c.j -4
        add_row(32'h0000_C401, 1, 32'h0004_0463, 1'b0);   // c.beqz +8
        add_row(32'h0000_FCFD, 1, 32'hFE04_9FE3, 1'b0);   // c.bnez -2
        add_row(32'h0000_0696, 1, 32'h0056_9693, 1'b0);   // c.slli
        add_row(32'hFFF0_2083, 2, 32'hFFF0_2083, 1'b0);   // aligned
        add_row(32'h0000_4722, 1, 32'h0081_2703, 1'b0);   // c.lwsp
        add_row(32'h0000_2000, 1, 32'h0000_0000, 1'b1);   // quadrant 0 funct3 001
        add_row(32'h0000_C63E, 1, 32'h00F1_2623, 1'b0);   // c.swsp
        add_row(32'h0000_0073, 2, 32'h0000_0073, 1'b0);   // straddles
        add_row(32'h0000_8282, 1, 32'h0002_8067, 1'b0);   // c.jr
        add_row(32'h0000_9302, 1, 32'h0003_00E7, 1'b0);   // c.jalr
        add_row(32'h0000_9002, 1, 32'h0010_0073, 1'b0);   // c.ebreak
        add_row(32'h0000_852E, 1, 32'h00B0_0533, 1'b0);   // c.mv
        add_row(32'h0000_952E, 1, 32'h00B5_0533, 1'b0);   // c.add
        load_memory();

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);                       // last reset cycle
        check_value("wb_cyc_o", wb_cyc_o, 1'b0);
        check_value("out_valid_o", out_valid_o, 1'b0);
        @(posedge clk_i);
        rst_i <= 1'b0;

        cycles = 0;
        while (!wb_cyc_o) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > 10) begin
                stop_run("wb_cyc_o did not rise after reset");
            end
        end
        check_value("wb_adr_o", wb_adr_o, RESET_PC);

        // walk the output slots in table order
        row    = 0;
        exp_pc = RESET_PC;
        while (row < prog.size()) begin
            cycles = 0;
            do begin
                @(negedge clk_i);
                cycles++;
                if (cycles > BEAT_TIMEOUT) begin
                    stop_run($sformatf("no output beat within %0d cycles, waiting for row %0d",
                                       BEAT_TIMEOUT, row));
                end
            end while (!(out_valid_o && out_ready_i));
            for (int k = 0; k < NUM_LANES; k++) begin
                if (out_slots_o[k].valid && row < prog.size()) begin
                    check_slot(k, prog[row], exp_pc);
                    exp_pc = exp_pc + XLEN'(2 * int'(prog[row].len));
                    row++;
                end
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule
